// File: verilog/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

////////////////////
// frame format
////////////////////
`define UART_DATA_BITS 8 // data bits per frame

////////////////////
// timing
////////////////////
`define UART_CLKS_PER_TICK 4 // clk cycles per oversample tick
`define UART_OVERSAMPLE 16 // ticks per bit, 64 clk per bit in this build

////////////////////
// queues
////////////////////
`define UART_TX_DEPTH 4 // power of two
`define UART_RX_DEPTH 4 // power of two

`endif

// File: verilog/uart_frame_pkg.sv
`default_nettype none

`include "uart_macros.svh"

package uart_frame_pkg;

	// one data byte
	typedef logic [`UART_DATA_BITS-1:0] data_t;

	// received word
	// msb is the frame error flag, the rest is the data byte
	typedef logic [`UART_DATA_BITS:0] rx_word_t;

	// transmit path
	typedef enum logic [1:0] {
		TX_IDLE, // line high, waiting on queue
		TX_START, // start bit low
		TX_DATA, // data bits lsb first
		TX_STOP // stop bit high
	} tx_state_t;

	// receive path
	typedef enum logic [1:0] {
		RX_IDLE, // waiting for falling edge
		RX_START, // checking start bit middle
		RX_DATA, // sampling data bits
		RX_STOP // checking stop bit
	} rx_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_status_pkg.sv
`default_nettype none

package uart_status_pkg;

	// sticky error flags
	typedef logic [1:0] err_vec_t;

	// bit positions in err_vec_t
	parameter int ERR_FRAME = 0; // stop bit seen low
	parameter int ERR_OVERRUN = 1; // word lost, rx queue full

	// a word is dropped only on overrun
	// its frame error still counts
	// both flags clear together on clear_err

endpackage

`default_nettype wire

// File: verilog/baud_gen.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// oversample tick for both serial paths
// used as a clock enable, never as a clock
module baud_gen (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	localparam int CW = $clog2(`UART_CLKS_PER_TICK);

	logic [CW-1:0] cnt; // clk cycles within one tick

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= 1'b0; // one cycle pulse
			if (cnt == CW'(`UART_CLKS_PER_TICK - 1)) begin
				cnt <= '0; // wrap
				tick <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_fifo.sv
`default_nettype none
`timescale 1ns/1ns

// circular buffer shared by both queues
// head word is visible on rdata whenever empty is low
module uart_fifo #(
	parameter type payload_t = uart_frame_pkg::data_t,
	parameter int DEPTH = 4 // power of two
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  logic     pop,
	input  payload_t wdata,
	output payload_t rdata,
	output logic     full,
	output logic     empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [DEPTH]; // storage
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count; // occupancy, 0 to DEPTH
	logic do_push;
	logic do_pop;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full; // push while full is dropped
	assign do_pop = pop && !empty; // pop while empty is ignored

	assign rdata = mem[rd_ptr]; // head of queue

	////////////////////
	// pointers and count
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	////////////////////
	// storage
	////////////////////
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// transmit serializer
// start bit, data lsb first, stop bit
module uart_tx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick,
	input  logic                  q_empty,
	input  uart_frame_pkg::data_t q_data,
	output logic                  q_pop,
	output logic                  txd,
	output logic                  busy
);

	localparam int TW = $clog2(`UART_OVERSAMPLE);
	localparam int BW = $clog2(`UART_DATA_BITS);

	uart_frame_pkg::tx_state_t state;
	uart_frame_pkg::data_t shreg; // byte being sent, shifts right
	logic [TW-1:0] tick_cnt; // ticks within current bit
	logic [BW-1:0] bit_cnt; // data bits sent
	logic tick_hit; // last tick of a bit
	logic bit_hit; // last data bit

	assign tick_hit = (tick_cnt == TW'(`UART_OVERSAMPLE - 1));
	assign bit_hit = (bit_cnt == BW'(`UART_DATA_BITS - 1));

	// pop only from idle
	assign q_pop = (state == uart_frame_pkg::TX_IDLE) && !q_empty;

	////////////////////
	// control fsm
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= uart_frame_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1; // line idles high
			busy <= 1'b0;
		end else begin
			case (state)
				uart_frame_pkg::TX_IDLE: begin
					txd <= 1'b1;
					tick_cnt <= '0;
					bit_cnt <= '0;
					busy <= !q_empty; // stays high across back-to-back frames
					if (!q_empty)
						state <= uart_frame_pkg::TX_START; // start bit on next tick
				end
				uart_frame_pkg::TX_START: if (tick) begin
					txd <= 1'b0;
					tick_cnt <= tick_cnt + 1'b1; // wraps after 16
					if (tick_hit)
						state <= uart_frame_pkg::TX_DATA;
				end
				uart_frame_pkg::TX_DATA: if (tick) begin
					txd <= shreg[0];
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_hit) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_hit)
							state <= uart_frame_pkg::TX_STOP;
					end
				end
				uart_frame_pkg::TX_STOP: if (tick) begin
					txd <= 1'b1;
					tick_cnt <= tick_cnt + 1'b1;
					// next start bit can begin right on the following tick
					if (tick_hit)
						state <= uart_frame_pkg::TX_IDLE;
				end
				default: state <= uart_frame_pkg::TX_IDLE;
			endcase
		end
	end

	// shift register, loaded on pop
	always_ff @(posedge clk) begin
		if (q_pop)
			shreg <= q_data;
		else if (state == uart_frame_pkg::TX_DATA && tick && tick_hit)
			shreg <= shreg >> 1; // next bit to lsb
	end

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// receive deserializer
// samples rxd at the middle of each bit
module uart_rx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     tick,
	input  logic                     rxd,
	output logic                     done,
	output uart_frame_pkg::rx_word_t word
);

	localparam int TW = $clog2(`UART_OVERSAMPLE);
	localparam int BW = $clog2(`UART_DATA_BITS);
	localparam int HALF = `UART_OVERSAMPLE / 2; // ticks to bit middle

	uart_frame_pkg::rx_state_t state;
	uart_frame_pkg::data_t shreg; // data bits, lsb arrives first
	logic [1:0] sync; // two-flop synchronizer
	logic rxd_s; // synchronized line
	logic rxd_q; // previous synchronized sample
	logic [TW-1:0] tick_cnt;
	logic [BW-1:0] bit_cnt;
	logic tick_hit;
	logic bit_hit;
	logic fall; // falling edge on synced line

	assign rxd_s = sync[1];
	assign fall = rxd_q && !rxd_s;
	assign tick_hit = (tick_cnt == TW'(`UART_OVERSAMPLE - 1));
	assign bit_hit = (bit_cnt == BW'(`UART_DATA_BITS - 1));

	////////////////////
	// sync and fsm
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync <= 2'b11; // idle high
			rxd_q <= 1'b1;
			state <= uart_frame_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			done <= 1'b0;
		end else begin
			sync <= {sync[0], rxd};
			rxd_q <= rxd_s;
			done <= 1'b0; // single cycle pulse
			case (state)
				uart_frame_pkg::RX_IDLE: begin
					tick_cnt <= '0;
					bit_cnt <= '0;
					if (fall)
						state <= uart_frame_pkg::RX_START;
				end
				uart_frame_pkg::RX_START: if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_cnt == TW'(HALF - 1)) begin // 8th tick
						tick_cnt <= '0; // realign to bit middle
						if (rxd_s)
							state <= uart_frame_pkg::RX_IDLE; // glitch, not a start bit
						else
							state <= uart_frame_pkg::RX_DATA;
					end
				end
				uart_frame_pkg::RX_DATA: if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_hit) begin // middle of data bit
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_hit)
							state <= uart_frame_pkg::RX_STOP;
					end
				end
				uart_frame_pkg::RX_STOP: if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_hit) begin // middle of stop bit
						done <= 1'b1;
						state <= uart_frame_pkg::RX_IDLE;
					end
				end
				default: state <= uart_frame_pkg::RX_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (state == uart_frame_pkg::RX_DATA && tick && tick_hit)
			shreg <= {rxd_s, shreg[`UART_DATA_BITS-1:1]}; // shift in from top
		if (state == uart_frame_pkg::RX_STOP && tick && tick_hit)
			word <= {!rxd_s, shreg}; // low stop bit is a frame error
	end

endmodule

`default_nettype wire

// File: verilog/uart_status.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// receive side bookkeeping
// push or drop, sticky errors, interrupt level
module uart_status (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     rx_done,
	input  uart_frame_pkg::rx_word_t rx_word,
	input  logic                     q_full,
	input  logic                     q_empty,
	input  logic                     clear_err,
	output logic                     push,
	output uart_frame_pkg::rx_word_t push_word,
	output uart_status_pkg::err_vec_t err,
	output logic                     irq
);

	uart_status_pkg::err_vec_t err_set;
	uart_status_pkg::err_vec_t err_next;
	logic push_next;

	assign push_next = rx_done && !q_full; // drop on overrun

	always_comb begin
		err_set = '0;
		err_set[uart_status_pkg::ERR_OVERRUN] = rx_done && q_full;
		err_set[uart_status_pkg::ERR_FRAME] = rx_done && rx_word[`UART_DATA_BITS];
		err_next = (clear_err ? '0 : err) | err_set; // set wins over clear
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			push <= 1'b0;
			err <= '0;
			irq <= 1'b0;
		end else begin
			push <= push_next;
			err <= err_next;
			// push and push_next cover the cycles before the queue shows the word
			irq <= !q_empty || push || push_next || (|err_next);
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (rx_done)
			push_word <= rx_word;
	end

endmodule

`default_nettype wire

// File: verilog/uart_link.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// full duplex uart link
module uart_link (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      tx_write,
	input  uart_frame_pkg::data_t     tx_data,
	output logic                      tx_full,
	output logic                      txd,
	output logic                      tx_busy,
	input  logic                      rxd,
	input  logic                      rx_read,
	output uart_frame_pkg::data_t     rx_data,
	output logic                      rx_frame_err,
	output logic                      rx_empty,
	output uart_status_pkg::err_vec_t err,
	output logic                      irq,
	input  logic                      clear_err
);

	logic tick; // shared oversample enable
	logic tx_q_empty;
	uart_frame_pkg::data_t tx_q_data;
	logic tx_pop;
	logic rx_done;
	uart_frame_pkg::rx_word_t rx_word;
	logic rx_push;
	uart_frame_pkg::rx_word_t rx_push_word;
	logic rx_q_full;
	uart_frame_pkg::rx_word_t rx_head; // head of rx queue

	assign rx_data = rx_head[`UART_DATA_BITS-1:0];
	assign rx_frame_err = rx_head[`UART_DATA_BITS];

	baud_gen baud_gen (.clk(clk), .rst(rst), .tick(tick));

	////////////////////
	// transmit path
	////////////////////
	uart_fifo #(
		.payload_t(uart_frame_pkg::data_t),
		.DEPTH(`UART_TX_DEPTH)
	) tx_queue (
		.clk(clk), .rst(rst),
		.push(tx_write), .pop(tx_pop),
		.wdata(tx_data), .rdata(tx_q_data),
		.full(tx_full), .empty(tx_q_empty)
	);

	uart_tx uart_tx (
		.clk(clk), .rst(rst), .tick(tick),
		.q_empty(tx_q_empty), .q_data(tx_q_data), .q_pop(tx_pop),
		.txd(txd), .busy(tx_busy)
	);

	////////////////////
	// receive path
	////////////////////
	uart_rx uart_rx (
		.clk(clk), .rst(rst), .tick(tick), .rxd(rxd),
		.done(rx_done), .word(rx_word)
	);

	uart_status uart_status (
		.clk(clk), .rst(rst),
		.rx_done(rx_done), .rx_word(rx_word),
		.q_full(rx_q_full), .q_empty(rx_empty), .clear_err(clear_err),
		.push(rx_push), .push_word(rx_push_word),
		.err(err), .irq(irq)
	);

	uart_fifo #(
		.payload_t(uart_frame_pkg::rx_word_t),
		.DEPTH(`UART_RX_DEPTH)
	) rx_queue (
		.clk(clk), .rst(rst),
		.push(rx_push), .pop(rx_read),
		.wdata(rx_push_word), .rdata(rx_head),
		.full(rx_q_full), .empty(rx_empty)
	);

endmodule

`default_nettype wire

// File: test/uart_link_check.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

// watches the link ports and compares against expected words
module uart_link_check (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  loopback, // txd feeds rxd
	input  logic                  tx_write,
	input  uart_frame_pkg::data_t tx_data,
	input  logic                  tx_full,
	input  logic                  txd,
	input  logic                  tx_busy,
	input  logic                  rx_read,
	input  uart_frame_pkg::data_t rx_data,
	input  logic                  rx_frame_err,
	input  logic                  rx_empty
);

	localparam int BIT_CLKS = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;

	uart_frame_pkg::rx_word_t exp_q[$]; // words expected on the rx queue
	uart_frame_pkg::data_t tx_q[$]; // bytes expected on txd
	string test_name = "reset";
	int checks = 0;
	int errors = 0;

	// expected rx word for a byte and the stop bit seen on the line
	function automatic uart_frame_pkg::rx_word_t ref_word(uart_frame_pkg::data_t d,
			logic stop);
		ref_word = {~stop, d}; // low stop bit flags a frame error
	endfunction

	task automatic check_val(string name, int exp, int act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic expect_word(uart_frame_pkg::data_t d, logic stop);
		exp_q.push_back(ref_word(d, stop));
	endtask

	// words that never showed up
	task automatic check_drained();
		checks++;
		if (exp_q.size() != 0) begin
			errors++;
			$display("%s: %0d expected words never arrived", test_name, exp_q.size());
		end
	endtask

	////////////////////
	// accepted writes
	////////////////////
	always @(posedge clk) begin
		if (!rst && tx_write && !tx_full && loopback) begin
			exp_q.push_back(ref_word(tx_data, 1'b1));
			tx_q.push_back(tx_data);
		end
	end

	////////////////////
	// rx reads
	////////////////////
	always @(posedge clk) begin
		if (!rst && rx_read && !rx_empty) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: word %0h read with none expected", test_name,
					{rx_frame_err, rx_data});
			end else begin
				check_val(test_name, exp_q.pop_front(), {rx_frame_err, rx_data});
			end
		end
	end

	////////////////////
	// bit format on txd
	////////////////////
	initial begin
		uart_frame_pkg::data_t b;
		logic [9:0] seen;
		logic [9:0] busy_seen;
		forever begin
			@(negedge txd);
			repeat (BIT_CLKS / 2) @(posedge clk); // middle of start bit
			seen[0] = txd;
			busy_seen[0] = tx_busy;
			for (int i = 1; i < 10; i++) begin
				repeat (BIT_CLKS) @(posedge clk);
				seen[i] = txd;
				busy_seen[i] = tx_busy;
			end
			if (tx_q.size() == 0) begin
				errors++;
				$display("bit_format: frame on txd without an accepted write");
			end else begin
				b = tx_q.pop_front();
				check_val("bit_format", {1'b1, b, 1'b0}, seen); // stop, data, start
				check_val("bit_format busy", 10'h3ff, busy_seen); // high through stop bit
			end
		end
	end

endmodule

`default_nettype wire

// File: test/uart_link_assert.sv
`default_nettype none
`timescale 1ns/1ns

// concurrent checks on the link top level
module uart_link_assert (
	input logic                      clk,
	input logic                      rst,
	input logic                      txd,
	input logic                      tx_busy,
	input logic                      tx_full,
	input logic                      rx_empty,
	input uart_status_pkg::err_vec_t err,
	input logic                      irq,
	input logic                      rx_push,
	input logic                      rx_done
);

	int fails = 0; // assertion failures so far

	// line idles high outside a frame
	idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> txd)
		else begin
			$error("txd low while transmitter idle");
			fails++;
		end

	// flags held during reset
	reset_flags: assert property (@(posedge clk)
		rst ##1 rst |-> !$rose(tx_full) && !$rose(rx_empty))
		else begin
			$error("queue flag rose during reset");
			fails++;
		end

	// irq follows queue and errors once inputs settle
	irq_level: assert property (@(posedge clk) disable iff (rst)
		(!rx_push && !rx_done) ##1 ($stable(rx_empty) && $stable(err))
		|-> irq == (!rx_empty || (|err)))
		else begin
			$error("irq does not match rx queue and error state");
			fails++;
		end

endmodule

bind uart_link uart_link_assert link_assert (
	.clk(clk), .rst(rst), .txd(txd), .tx_busy(tx_busy), .tx_full(tx_full),
	.rx_empty(rx_empty), .err(err), .irq(irq), .rx_push(rx_push), .rx_done(rx_done)
);

`default_nettype wire

// File: test/uart_link_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "uart_macros.svh"

module uart_link_tb;

	localparam int BIT_CLKS = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;
	localparam int FRAME_CLKS = BIT_CLKS * 10;
	localparam int LIMIT = 4 * 12 * FRAME_CLKS + 4000; // four phases plus margin

	logic clk;
	logic rst;
	logic tx_write;
	uart_frame_pkg::data_t tx_data;
	logic tx_full;
	logic txd;
	logic tx_busy;
	logic rx_read;
	uart_frame_pkg::data_t rx_data;
	logic rx_frame_err;
	logic rx_empty;
	uart_status_pkg::err_vec_t err;
	logic irq;
	logic clear_err;
	logic loopback;
	logic inj_line; // injected serial line
	logic rxd;
	logic saw_full;
	int seed = 32'ha1384cac;
	int cycles = 0;
	uart_frame_pkg::data_t b;

	assign rxd = loopback ? txd : inj_line;

	uart_link uut (
		.clk(clk), .rst(rst), .tx_write(tx_write), .tx_data(tx_data),
		.tx_full(tx_full), .txd(txd), .tx_busy(tx_busy), .rxd(rxd),
		.rx_read(rx_read), .rx_data(rx_data), .rx_frame_err(rx_frame_err),
		.rx_empty(rx_empty), .err(err), .irq(irq), .clear_err(clear_err)
	);

	uart_link_check chk (
		.clk(clk), .rst(rst), .loopback(loopback), .tx_write(tx_write),
		.tx_data(tx_data), .tx_full(tx_full), .txd(txd), .tx_busy(tx_busy),
		.rx_read(rx_read), .rx_data(rx_data), .rx_frame_err(rx_frame_err),
		.rx_empty(rx_empty)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("test failed");
			$finish;
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////
	task automatic write_byte(uart_frame_pkg::data_t d);
		@(posedge clk);
		while (tx_full)
			@(posedge clk);
		tx_write <= 1'b1;
		tx_data <= d;
		@(posedge clk);
		tx_write <= 1'b0;
	endtask

	// read whenever a word waits, until the link stays quiet a frame and more
	task automatic drain();
		int quiet;
		quiet = 0;
		while (quiet < FRAME_CLKS + 128) begin
			@(posedge clk);
			rx_read <= !rx_empty && !rx_read;
			if (rx_empty && !tx_busy && !rx_read)
				quiet++;
			else
				quiet = 0;
		end
		rx_read <= 1'b0;
	endtask

	task automatic send_frame(uart_frame_pkg::data_t d, logic stop);
		logic [9:0] bits;
		bits = {stop, d, 1'b0}; // lsb goes out first
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			inj_line <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		inj_line <= 1'b1;
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		clear_err <= 1'b1;
		@(posedge clk);
		clear_err <= 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		tx_write = 1'b0;
		tx_data = '0;
		rx_read = 1'b0;
		clear_err = 1'b0;
		loopback = 1'b1;
		inj_line = 1'b1;
		saw_full = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		@(posedge clk);

		// reset state
		chk.check_val("reset txd", 1, txd);
		chk.check_val("reset tx_full", 0, tx_full);
		chk.check_val("reset irq", 0, irq);
		chk.check_val("reset rx_empty", 1, rx_empty);
		chk.check_val("reset err", 0, err);

		////////////////////
		// loopback, random bytes
		////////////////////
		chk.test_name = "loopback";
		fork
			for (int i = 0; i < 20; i++) begin
				b = $random(seed);
				write_byte(b);
			end
			drain();
		join
		chk.check_drained();

		// six writes on consecutive cycles
		chk.test_name = "backpressure";
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			if (tx_full)
				saw_full = 1'b1;
			tx_write <= 1'b1;
			tx_data <= $random(seed);
		end
		@(posedge clk);
		if (tx_full)
			saw_full = 1'b1; // queue full when the sixth write lands
		tx_write <= 1'b0;
		chk.check_val("backpressure tx_full seen", 1, saw_full);
		drain();
		chk.check_drained();

		////////////////////
		// framing error, injected
		////////////////////
		chk.test_name = "framing";
		loopback <= 1'b0;
		b = $random(seed);
		chk.expect_word(b, 1'b0);
		send_frame(b, 1'b0);
		while (rx_empty)
			@(posedge clk);
		repeat (2) @(posedge clk);
		chk.check_val("framing err frame bit", 1, err[uart_status_pkg::ERR_FRAME]);
		chk.check_val("framing irq set", 1, irq);
		pulse_clear();
		repeat (2) @(posedge clk);
		chk.check_val("framing err cleared", 0, err);
		chk.check_val("framing irq held", 1, irq);
		drain();
		chk.check_val("framing irq released", 0, irq);
		chk.check_drained();

		////////////////////
		// overrun, no reads
		////////////////////
		chk.test_name = "overrun";
		for (int i = 0; i < 5; i++) begin
			b = $random(seed);
			if (i < 4)
				chk.expect_word(b, 1'b1); // fifth is dropped
			send_frame(b, 1'b1);
		end
		repeat (4) @(posedge clk);
		chk.check_val("overrun err bit", 1, err[uart_status_pkg::ERR_OVERRUN]);
		drain();
		chk.check_drained();
		pulse_clear();
		repeat (2) @(posedge clk);
		chk.check_val("overrun err cleared", 0, err);

		$display("checks %0d, errors %0d, assertion failures %0d", chk.checks, chk.errors,
			uut.link_assert.fails);
		if (chk.errors == 0 && uut.link_assert.fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/uart_frame_pkg.sv
verilog/uart_status_pkg.sv
verilog/baud_gen.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_status.sv
verilog/uart_link.sv
test/uart_link_check.sv
test/uart_link_assert.sv
test/uart_link_tb.sv
